// File: rtl/offload_pkg.sv
/* Transport widths and payload structs of the offload request and response paths
   Imported by every block that carries a request or a response */
package offload_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int DataWidth = 32;
  localparam int AddrWidth = 32;
  localparam int OpWidth   = 4;
  // Default id width, the top level overrides it through its own parameter
  localparam int IdWidth   = 5;

  // ------------------------------
  // Payloads
  // ------------------------------
  // Request as issued by the core side
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [IdWidth-1:0]   id;
    logic [OpWidth-1:0]   op;
    logic [DataWidth-1:0] arga;
    logic [DataWidth-1:0] argb;
  } offload_req_t;

  // Response returned by one of the units
  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [IdWidth-1:0]   id;
    logic                 error;
  } offload_resp_t;

endpackage

// File: rtl/op_pkg.sv
/* Operation word encodings of the two execution units
   The same 4-bit word is decoded by the multiply unit or by the ALU */
package op_pkg;

  // Multiply view of the operation word
  typedef struct packed {
    logic reserved;  // Must be zero
    logic high;      // Upper product half
    logic signed_a;
    logic signed_b;
  } mul_op_t;

  // ALU function codes
  // Code 7 is left unassigned and flags an error
  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    SLL = 3'd5,
    SRL = 3'd6
  } alu_op_e;

  // ALU view of the operation word
  typedef struct packed {
    logic    reserved;  // Must be zero
    alu_op_e func;
  } alu_op_t;

  // One word, two decodings
  typedef union packed {
    mul_op_t mul;
    alu_op_t alu;
  } op_word_u;

  // Address bit 0 selects the unit
  localparam logic UnitMul = 1'b0;
  localparam logic UnitAlu = 1'b1;

endpackage

// File: rtl/offload_if.sv
`timescale 1ns/1ps
/* Valid/ready request and response links between the blocks of the cluster
   src drives payload and valid, dst returns ready */
interface offload_req_if
  import offload_pkg::*;
#(
  parameter int IdWidth = offload_pkg::IdWidth
) ();
  logic         valid;
  logic         ready;
  offload_req_t req;
  // Id view for the receiving unit
  logic [IdWidth-1:0] id;

  assign id = req.id;

  modport src (output valid, output req, input ready);
  modport dst (input valid, input req, input id, output ready);
endinterface

interface offload_resp_if
  import offload_pkg::*;
#(
  parameter int IdWidth = offload_pkg::IdWidth
) ();
  logic          valid;
  logic          ready;
  offload_resp_t resp;
  // Id view for the arbiter
  logic [IdWidth-1:0] id;

  assign id = resp.id;

  modport src (output valid, output resp, input ready);
  modport dst (input valid, input resp, input id, output ready);
endinterface

// File: rtl/spill_register.sv
`timescale 1ns/1ps
/* Two-slot valid/ready register slice that cuts every path at full throughput
   With Bypass set it collapses to plain wires */
module spill_register #(
  parameter type T      = logic,
  parameter bit  Bypass = 1'b0
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  input  T     data_i,
  input  logic ready_i,
  output logic ready_o,
  output logic valid_o,
  output T     data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    // Slot a takes new items, slot b catches what a cannot hand on
    logic a_full_q, b_full_q;
    T     a_data_q, b_data_q;
    logic a_fill, a_drain, b_fill, b_drain;

    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    // Spill into b only when the sink stalls
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    // Payload slots
    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // b always holds the older item
    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;
  end

endmodule

// File: rtl/offload_issue.sv
`timescale 1ns/1ps
/* Input side of the cluster
   Cuts the request path and steers each request to a unit by address bit 0 */
module offload_issue
  import offload_pkg::*;
  import op_pkg::*;
#(
  parameter int IdWidth     = offload_pkg::IdWidth,
  parameter bit RegisterReq = 1'b1
) (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          req_valid_i,
  input  offload_req_t  req_i,
  output logic          req_ready_o,
  offload_req_if.src    mul_o,
  offload_req_if.src    alu_o
);

  offload_req_t req_q;
  logic         req_qvalid, req_qready;
  logic         sel_alu;

  // Request cut
  spill_register #(
    .T      ( offload_req_t ),
    .Bypass ( !RegisterReq  )
  ) i_spill_register_req (
    .clk_i   ( clk_i       ),
    .rst_i   ( rst_i       ),
    .valid_i ( req_valid_i ),
    .data_i  ( req_i       ),
    .ready_i ( req_qready  ),
    .ready_o ( req_ready_o ),
    .valid_o ( req_qvalid  ),
    .data_o  ( req_q       )
  );

  // ------------------------------
  // Routing
  // ------------------------------
  assign sel_alu = (req_q.addr[0] == UnitAlu);

  // Payload goes to both, valid only to the selected unit
  assign mul_o.req   = req_q;
  assign alu_o.req   = req_q;
  assign mul_o.valid = req_qvalid && (req_q.addr[0] == UnitMul);
  assign alu_o.valid = req_qvalid && sel_alu;

  // A busy unit holds the request in place
  assign req_qready = sel_alu ? alu_o.ready : mul_o.ready;

endmodule

// File: rtl/mul_unit.sv
`timescale 1ns/1ps
/* Two-stage 32x32 multiplier on the offload path
   Returns the low or high product half, signedness chosen per operand */
module mul_unit
  import offload_pkg::*;
  import op_pkg::*;
#(
  parameter int IdWidth = offload_pkg::IdWidth
) (
  input  logic        clk_i,
  input  logic        rst_i,
  offload_req_if.dst  req_i,
  offload_resp_if.src resp_o
);

  op_word_u op;
  logic     s1_ready, s2_ready;

  // Stage one holds the extended operands
  logic                        s1_valid_q, s1_high_q, s1_err_q;
  logic signed [DataWidth:0]   s1_a_q, s1_b_q;
  logic [IdWidth-1:0]          s1_id_q;
  // Stage two holds the full product
  logic                        s2_valid_q, s2_high_q, s2_err_q;
  logic [2*DataWidth-1:0]      s2_prod_q;
  logic [IdWidth-1:0]          s2_id_q;
  logic signed [2*DataWidth+1:0] prod;
  logic [DataWidth-1:0]        result;

  assign op = req_i.req.op;

  // A stage moves when the next one is empty or being emptied
  assign s2_ready    = !s2_valid_q || resp_o.ready;
  assign s1_ready    = !s1_valid_q || s2_ready;
  assign req_i.ready = s1_ready;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid_q <= req_i.valid;
      end
      if (s2_ready) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  // 33-bit signed operands cover both unsigned and signed inputs
  assign prod = s1_a_q * s1_b_q;

  always_ff @(posedge clk_i) begin
    if (req_i.valid && s1_ready) begin
      s1_a_q    <= {op.mul.signed_a & req_i.req.arga[DataWidth-1], req_i.req.arga};
      s1_b_q    <= {op.mul.signed_b & req_i.req.argb[DataWidth-1], req_i.req.argb};
      s1_high_q <= op.mul.high;
      s1_err_q  <= op.mul.reserved;
      s1_id_q   <= req_i.id;
    end
    if (s1_valid_q && s2_ready) begin
      s2_prod_q <= prod[2*DataWidth-1:0];
      s2_high_q <= s1_high_q;
      s2_err_q  <= s1_err_q;
      s2_id_q   <= s1_id_q;
    end
  end

  // Half select, zero data on error
  assign result = s2_err_q  ? '0 :
                  s2_high_q ? s2_prod_q[2*DataWidth-1:DataWidth] : s2_prod_q[DataWidth-1:0];

  assign resp_o.valid = s2_valid_q;
  assign resp_o.resp  = '{data: result, id: s2_id_q, error: s2_err_q};

endmodule

// File: rtl/alu_unit.sv
`timescale 1ns/1ps
/* Single-stage integer ALU on the offload path
   One output register, refilled in the cycle its result is taken */
module alu_unit
  import offload_pkg::*;
  import op_pkg::*;
#(
  parameter int IdWidth = offload_pkg::IdWidth
) (
  input  logic        clk_i,
  input  logic        rst_i,
  offload_req_if.dst  req_i,
  offload_resp_if.src resp_o
);

  op_word_u             op;
  logic [DataWidth-1:0] a, b, result;
  logic                 illegal;
  logic                 valid_q, err_q;
  logic [DataWidth-1:0] data_q;
  logic [IdWidth-1:0]   id_q;

  assign op = req_i.req.op;
  assign a  = req_i.req.arga;
  assign b  = req_i.req.argb;

  always_comb begin
    illegal = op.alu.reserved;
    case (op.alu.func)
      ADD:     result = a + b;
      SUB:     result = a - b;
      AND:     result = a & b;
      OR:      result = a | b;
      XOR:     result = a ^ b;
      // Shift amount from the low 5 bits
      SLL:     result = a << b[4:0];
      SRL:     result = a >> b[4:0];
      default: begin
        result  = '0;
        illegal = 1'b1;
      end
    endcase
    if (illegal) begin
      result = '0;
    end
  end

  // Free when empty or when the held result leaves
  assign req_i.ready = !valid_q || resp_o.ready;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (req_i.ready) begin
      valid_q <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid && req_i.ready) begin
      data_q <= result;
      err_q  <= illegal;
      id_q   <= req_i.id;
    end
  end

  assign resp_o.valid = valid_q;
  assign resp_o.resp  = '{data: data_q, id: id_q, error: err_q};

endmodule

// File: rtl/resp_collect.sv
`timescale 1ns/1ps
/* Output side of the cluster
   Round-robin merge of the two unit responses, then the response cut */
module resp_collect
  import offload_pkg::*;
#(
  parameter int IdWidth      = offload_pkg::IdWidth,
  parameter bit RegisterResp = 1'b1
) (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          resp_ready_i,
  offload_resp_if.dst   mul_i,
  offload_resp_if.dst   alu_i,
  output logic          resp_valid_o,
  output offload_resp_t resp_o
);

  // Set when the ALU wins a tie
  logic               rr_q;
  logic               grant_alu;
  logic               arb_valid, arb_ready;
  logic [IdWidth-1:0] arb_id;
  offload_resp_t      arb_resp;

  // ------------------------------
  // Arbiter
  // ------------------------------
  // Pointer decides only on a tie
  assign grant_alu = (mul_i.valid && alu_i.valid) ? rr_q : alu_i.valid;
  assign arb_valid = mul_i.valid || alu_i.valid;
  assign arb_id    = grant_alu ? alu_i.id : mul_i.id;

  assign arb_resp = '{
    data:  grant_alu ? alu_i.resp.data : mul_i.resp.data,
    id:    arb_id,
    error: grant_alu ? alu_i.resp.error : mul_i.resp.error
  };

  assign mul_i.ready = arb_ready && !grant_alu;
  assign alu_i.ready = arb_ready && grant_alu;

  // Pass priority on past the winner after a handshake
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rr_q <= 1'b0;
    end else if (arb_valid && arb_ready) begin
      rr_q <= !grant_alu;
    end
  end

  // Response cut
  spill_register #(
    .T      ( offload_resp_t ),
    .Bypass ( !RegisterResp  )
  ) i_spill_register_resp (
    .clk_i   ( clk_i        ),
    .rst_i   ( rst_i        ),
    .valid_i ( arb_valid    ),
    .data_i  ( arb_resp     ),
    .ready_i ( resp_ready_i ),
    .ready_o ( arb_ready    ),
    .valid_o ( resp_valid_o ),
    .data_o  ( resp_o       )
  );

endmodule

// File: rtl/offload_cluster.sv
`timescale 1ns/1ps
/* Top level of the accelerator offload cluster
   Requests enter on acc_q*, responses leave on acc_p*, matched by id */
module offload_cluster
  import offload_pkg::*;
#(
  parameter int IdWidth      = 5,
  parameter bit RegisterReq  = 1'b1,
  parameter bit RegisterResp = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Request port
  input  logic [AddrWidth-1:0] acc_qaddr_i,
  input  logic [IdWidth-1:0]   acc_qid_i,
  input  logic [OpWidth-1:0]   acc_qop_i,
  input  logic [DataWidth-1:0] acc_qarga_i,
  input  logic [DataWidth-1:0] acc_qargb_i,
  input  logic                 acc_qvalid_i,
  output logic                 acc_qready_o,
  // Response port
  output logic [DataWidth-1:0] acc_pdata_o,
  output logic [IdWidth-1:0]   acc_pid_o,
  output logic                 acc_perror_o,
  output logic                 acc_pvalid_o,
  input  logic                 acc_pready_i
);

  offload_req_t  req;
  offload_resp_t resp;

  offload_req_if  #(.IdWidth(IdWidth)) mul_req ();
  offload_req_if  #(.IdWidth(IdWidth)) alu_req ();
  offload_resp_if #(.IdWidth(IdWidth)) mul_resp ();
  offload_resp_if #(.IdWidth(IdWidth)) alu_resp ();

  // Pack the request port
  assign req = '{addr: acc_qaddr_i, id: acc_qid_i, op: acc_qop_i,
                 arga: acc_qarga_i, argb: acc_qargb_i};

  offload_issue #(.IdWidth(IdWidth), .RegisterReq(RegisterReq)) i_offload_issue (
    .clk_i       ( clk_i        ),
    .rst_i       ( rst_i        ),
    .req_valid_i ( acc_qvalid_i ),
    .req_i       ( req          ),
    .req_ready_o ( acc_qready_o ),
    .mul_o       ( mul_req      ),
    .alu_o       ( alu_req      )
  );

  mul_unit #(.IdWidth(IdWidth)) i_mul_unit (.clk_i, .rst_i, .req_i(mul_req), .resp_o(mul_resp));
  alu_unit #(.IdWidth(IdWidth)) i_alu_unit (.clk_i, .rst_i, .req_i(alu_req), .resp_o(alu_resp));

  resp_collect #(.IdWidth(IdWidth), .RegisterResp(RegisterResp)) i_resp_collect (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .resp_ready_i ( acc_pready_i ),
    .mul_i        ( mul_resp     ),
    .alu_i        ( alu_resp     ),
    .resp_valid_o ( acc_pvalid_o ),
    .resp_o       ( resp         )
  );

  // Unpack the response port
  assign acc_pdata_o  = resp.data;
  assign acc_pid_o    = resp.id;
  assign acc_perror_o = resp.error;

endmodule

// File: testbench/offload_model.svh
/* Reference model of the multiply unit and the ALU, included by the testbench
   Expected results wait in a table indexed by request id until their response */
`ifndef OFFLOAD_MODEL_SVH
`define OFFLOAD_MODEL_SVH

// ------------------------------
// Expectation table
// ------------------------------
logic                 pending     [NumIds];
logic [DataWidth-1:0] exp_data    [NumIds];
logic                 exp_error   [NumIds];
int                   issue_cycle [NumIds];
int                   outstanding;
int                   completed;

// Product of both operands, each widened by its own sign flag
// Result is {error, data}
function automatic logic [DataWidth:0] mul_expect(input logic [OpWidth-1:0] op,
                                                  input logic [DataWidth-1:0] a,
                                                  input logic [DataWidth-1:0] b);
  mul_op_t     m;
  logic [63:0] wide_a, wide_b, prod;
  m      = mul_op_t'(op);
  wide_a = m.signed_a ? {{32{a[31]}}, a} : {32'd0, a};
  wide_b = m.signed_b ? {{32{b[31]}}, b} : {32'd0, b};
  // Low 64 bits of the 64x64 product equal the exact product
  prod   = wide_a * wide_b;
  if (m.reserved) begin
    return {1'b1, 32'd0};
  end
  return {1'b0, m.high ? prod[63:32] : prod[31:0]};
endfunction

function automatic logic [DataWidth:0] alu_expect(input logic [OpWidth-1:0] op,
                                                  input logic [DataWidth-1:0] a,
                                                  input logic [DataWidth-1:0] b);
  logic [DataWidth-1:0] r;
  logic                 err;
  err = op[3];
  r   = '0;
  case (alu_op_e'(op[2:0]))
    ADD:     r = a + b;
    SUB:     r = a - b;
    AND:     r = a & b;
    OR:      r = a | b;
    XOR:     r = a ^ b;
    SLL:     r = a << b[4:0];
    SRL:     r = a >> b[4:0];
    default: err = 1'b1;  // Code 7
  endcase
  return err ? {1'b1, 32'd0} : {1'b0, r};
endfunction

task automatic clear_model();
  for (int i = 0; i < NumIds; i++) begin
    pending[i]     = 1'b0;
    exp_data[i]    = '0;
    exp_error[i]   = 1'b0;
    issue_cycle[i] = 0;
  end
  outstanding = 0;
  completed   = 0;
endtask

// Store the expectation of an accepted request under its id
task automatic record_issue(input logic [IdWidth-1:0] id, input logic [AddrWidth-1:0] addr,
                            input logic [OpWidth-1:0] op, input logic [DataWidth-1:0] a,
                            input logic [DataWidth-1:0] b);
  logic [DataWidth:0] res;
  res = (addr[0] == UnitAlu) ? alu_expect(op, a, b) : mul_expect(op, a, b);
  pending[id]     = 1'b1;
  exp_error[id]   = res[DataWidth];
  exp_data[id]    = res[DataWidth-1:0];
  issue_cycle[id] = cycle;
  outstanding++;
endtask

`endif

// File: testbench/tb_offload_cluster.sv
`timescale 1ns/1ps
/* Testbench of the offload cluster
   Random requests to both units, responses matched by id against a model */
module tb_offload_cluster
  import offload_pkg::*;
  import op_pkg::*;
();

  localparam int IdWidth      = 5;
  localparam int NumIds       = 1 << IdWidth;
  localparam int NumReqs      = 400;
  localparam int ReqTimeout   = 200;
  localparam int DrainTimeout = 2000;
  localparam int MaxLatency   = 300;

  logic                 clk_i, rst_i;
  logic [AddrWidth-1:0] acc_qaddr_i;
  logic [IdWidth-1:0]   acc_qid_i;
  logic [OpWidth-1:0]   acc_qop_i;
  logic [DataWidth-1:0] acc_qarga_i, acc_qargb_i;
  logic                 acc_qvalid_i, acc_qready_o;
  logic [DataWidth-1:0] acc_pdata_o;
  logic [IdWidth-1:0]   acc_pid_o;
  logic                 acc_perror_o, acc_pvalid_o, acc_pready_i;

  integer seed;
  int     mismatch_cnt, fail_cnt, cycle;
  int     issued, gap, idle;
  logic   q_fire, abort;

  `include "offload_model.svh"

  offload_cluster #(.IdWidth(IdWidth)) offload_cluster_i (
    .clk_i, .rst_i, .acc_qaddr_i, .acc_qid_i, .acc_qop_i, .acc_qarga_i, .acc_qargb_i,
    .acc_qvalid_i, .acc_qready_o, .acc_pdata_o, .acc_pid_o, .acc_perror_o,
    .acc_pvalid_o, .acc_pready_i
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ------------------------------
  // Stimulus and response checks
  // ------------------------------
  // Compare one response with the table entry of its id
  task automatic check_response(input logic [IdWidth-1:0] id, input logic [DataWidth-1:0] data,
                                input logic err);
    if ($isunknown(id) || !pending[id]) begin
      fail_cnt++;
      $display("%0t: response with id %0d that has no outstanding request", $time, id);
    end else begin
      if (data !== exp_data[id]) begin
        mismatch_cnt++;
        $display("mismatch at %0t: acc_pdata_o id %0d expected %h actual %h",
                 $time, id, exp_data[id], data);
      end
      if (err !== exp_error[id]) begin
        mismatch_cnt++;
        $display("mismatch at %0t: acc_perror_o id %0d expected %b actual %b",
                 $time, id, exp_error[id], err);
      end
      // Starvation shows up as an overlong latency
      if (cycle - issue_cycle[id] > MaxLatency) begin
        fail_cnt++;
        $display("%0t: id %0d took %0d cycles, longer than %0d",
                 $time, id, cycle - issue_cycle[id], MaxLatency);
      end
      pending[id] = 1'b0;
      outstanding--;
      completed++;
    end
  endtask

  // Pick a free id from a random start and raise a new request
  task automatic start_request();
    logic [31:0] rnd;
    logic        found;
    int          start;
    found = 1'b0;
    rnd   = $random(seed);
    start = int'(rnd[IdWidth-1:0]);
    for (int k = 0; k < NumIds; k++) begin
      if (!found && !pending[(start + k) % NumIds]) begin
        found     = 1'b1;
        acc_qid_i = IdWidth'((start + k) % NumIds);
      end
    end
    if (found) begin
      acc_qaddr_i  = $random(seed);
      rnd          = $random(seed);
      // Reserved bit on in about one request of eight
      acc_qop_i    = {rnd[3] & (rnd[5:4] == 2'b00), rnd[2:0]};
      acc_qarga_i  = $random(seed);
      acc_qargb_i  = $random(seed);
      acc_qvalid_i = 1'b1;
    end
  endtask

  // Drive on the falling edge and sample the settled handshakes one step later
  task automatic step_cycle(input bit allow_new);
    logic [31:0] rnd;
    @(negedge clk_i);
    cycle++;
    if (q_fire) begin
      acc_qvalid_i = 1'b0;
      rnd = $random(seed);
      gap = (rnd[3:2] == 2'b00) ? 3 * int'(rnd[1:0]) : 0;
    end
    rnd = $random(seed);
    if (rnd[2:0] == 3'd0) begin
      acc_pready_i = ~acc_pready_i;
    end
    if (allow_new && !acc_qvalid_i && issued < NumReqs) begin
      if (gap > 0) begin
        gap--;
      end else begin
        start_request();
      end
    end
    if (allow_new) begin
      idle++;
      if (idle > ReqTimeout) begin
        fail_cnt++;
        $display("%0t: no request accepted for %0d cycles", $time, ReqTimeout);
        abort = 1'b1;
      end
    end
    #1;
    // Inputs and DUT outputs now hold until the next rising edge
    q_fire = acc_qvalid_i && acc_qready_o;
    if (q_fire) begin
      record_issue(acc_qid_i, acc_qaddr_i, acc_qop_i, acc_qarga_i, acc_qargb_i);
      issued++;
      idle = 0;
    end
    if (acc_pvalid_o && acc_pready_i) begin
      check_response(acc_pid_o, acc_pdata_o, acc_perror_o);
    end
  endtask

  initial begin
    int drain;
    seed         = 32'h3e1c;
    rst_i        = 1'b1;
    acc_qaddr_i  = '0;
    acc_qid_i    = '0;
    acc_qop_i    = '0;
    acc_qarga_i  = '0;
    acc_qargb_i  = '0;
    acc_qvalid_i = 1'b0;
    acc_pready_i = 1'b0;
    mismatch_cnt = 0;
    fail_cnt     = 0;
    cycle        = 0;
    issued       = 0;
    gap          = 0;
    idle         = 0;
    q_fire       = 1'b0;
    abort        = 1'b0;
    clear_model();

    // No response may show up during reset or right after it
    repeat (5) begin
      @(negedge clk_i);
      if (acc_pvalid_o !== 1'b0) begin
        mismatch_cnt++;
        $display("mismatch at %0t: acc_pvalid_o expected 0 actual %b", $time, acc_pvalid_o);
      end
    end
    rst_i = 1'b0;
    // Empty cluster takes requests once reset is released
    repeat (2) begin
      @(negedge clk_i);
      if (acc_pvalid_o !== 1'b0) begin
        mismatch_cnt++;
        $display("mismatch at %0t: acc_pvalid_o expected 0 actual %b", $time, acc_pvalid_o);
      end
      if (acc_qready_o !== 1'b1) begin
        mismatch_cnt++;
        $display("mismatch at %0t: acc_qready_o expected 1 actual %b", $time, acc_qready_o);
      end
    end

    // Sustained random load on both units
    while (issued < NumReqs && !abort) begin
      step_cycle(1'b1);
    end

    // Drain
    drain = 0;
    while (outstanding > 0 && drain < DrainTimeout) begin
      step_cycle(1'b0);
      drain++;
    end
    for (int i = 0; i < NumIds; i++) begin
      if (pending[i]) begin
        fail_cnt++;
        $display("id %0d never returned a response", i);
      end
    end
    // Late or duplicate responses still get caught here
    repeat (10) step_cycle(1'b0);

    $display("responses %0d of %0d, mismatches %0d, other errors %0d",
             completed, issued, mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+testbench
rtl/offload_pkg.sv
rtl/op_pkg.sv
rtl/offload_if.sv
rtl/spill_register.sv
rtl/offload_issue.sv
rtl/mul_unit.sv
rtl/alu_unit.sv
rtl/resp_collect.sv
rtl/offload_cluster.sv
testbench/tb_offload_cluster.sv

// File: run.sh
#!/bin/sh
# Build the offload cluster testbench with Verilator, run it, judge the log
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal -f compile.f --top-module tb_offload_cluster \
  -Mdir obj_dir -o sim_offload
./obj_dir/sim_offload > sim.log 2>&1
cat sim.log

if grep -q "NO ERRORS" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
